// File: flist.f
design/decode_pkg.sv
design/pipe_reg.sv
design/regfile.sv
design/inst_decoder.sv
design/branch_unit.sv
design/id_stage.sv
bench/id_properties.sv
bench/id_checker.sv
bench/tb_id_stage.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_id_stage -f flist.f -o sim_id_stage

# the pipeline status is the status of grep, so a missing pass line fails the script
./obj_dir/sim_id_stage | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null
echo "simulation passed"

// File: bench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import decode_pkg::*;

    localparam int num_insts  = 600;
    localparam int wait_limit = 100;

    localparam logic [5:0] r_functs [8] = '{
        funct_addu, funct_subu, funct_slt, funct_sltu,
        funct_and, funct_or, funct_xor, funct_nor
    };
    localparam logic [5:0] shift_functs [4] = '{funct_sll, funct_srl, funct_sra, funct_sll};
    localparam logic [5:0] imm_ops [8] = '{
        op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui, op_addiu
    };
    localparam logic [5:0] load_ops [8] = '{
        op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lw, op_lb, op_lh
    };
    localparam logic [5:0] store_ops [4] = '{op_sb, op_sh, op_sw, op_sw};
    localparam logic [5:0] branch_ops [8] = '{
        op_beq, op_bne, op_blez, op_bgtz, op_regimm, op_regimm, op_beq, op_bne
    };

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    logic            in_ready;
    fetch_bundle_t   in_bundle;
    logic            out_valid;
    logic            out_ready;
    decoded_bundle_t out_bundle;
    rf_write_t       wb;
    logic [31:0]     stim_state;
    logic [31:0]     stall_state;
    logic            timed_out;
    int              sent;
    int              bench_errors;
    int              chk_errors;
    int              chk_checked;
    int              chk_pending;

    id_stage u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle),
        .wb         (wb)
    );

    id_checker u_checker (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle),
        .wb         (wb),
        .errors     (chk_errors),
        .checked    (chk_checked),
        .pending    (chk_pending)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    // r1 picks the instruction class, r2 fills the fields
    function automatic logic [31:0] make_inst(input logic [31:0] r1, input logic [31:0] r2);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  op;
        logic [15:0] imm;
        logic [31:0] word;
        rs  = r2[4:0];
        rt  = r2[9:5];
        rd  = r2[14:10];
        imm = r2[31:16];
        case (r1[2:0])
            3'd0: word = {op_special, rs, rt, rd, 5'd0, r_functs[r1[5:3]]};
            3'd1: word = {op_special, 5'd0, rt, rd, r2[19:15], shift_functs[r1[4:3]]};
            3'd2: begin
                op   = imm_ops[r1[5:3]];
                word = {op, (op == op_lui) ? 5'd0 : rs, rt, imm};
            end
            3'd3: word = {load_ops[r1[5:3]], rs, rt, imm};
            3'd4: word = {store_ops[r1[4:3]], rs, rt, imm};
            3'd5: begin
                op = branch_ops[r1[5:3]];
                if (op == op_regimm) begin
                    rt = {4'd0, r1[6]};
                end else if (op == op_blez || op == op_bgtz) begin
                    rt = 5'd0;
                end else if (r1[7]) begin
                    rt = rs;
                end
                word = {op, rs, rt, imm};
            end
            3'd6: begin
                case (r1[4:3])
                    2'd0:    word = {op_j, r2[25:0]};
                    2'd1:    word = {op_jal, r2[25:0]};
                    default: word = {op_special, rs, 15'd0, funct_jr};
                endcase
            end
            // raw words, opcode 3f is never a valid instruction
            default: word = r1[3] ? {6'h3f, r2[25:0]} : r2;
        endcase
        return word;
    endfunction

    // random back-pressure from the execute side
    always @(negedge clk) begin
        stall_state = xorshift32(stall_state);
        out_ready   = (stall_state[2:0] > 3'd2);
    end

    task automatic preload_regs();
        logic [31:0] value;
        for (int i = 0; i < num_regs; i++) begin
            value = next_stim();
            // zero registers for the blez and bgez edge
            if (i == 7 || i == 20) begin
                value = '0;
            end
            @(negedge clk);
            wb.we   = 1'b1;
            wb.addr = 5'(i);
            wb.data = value;
        end
        @(negedge clk);
        wb.we = 1'b0;
    endtask

    task automatic send_inst(input fetch_bundle_t fb);
        int   waited;
        logic taken;
        if (!timed_out) begin
            waited    = 0;
            taken     = 1'b0;
            in_valid  = 1'b1;
            in_bundle = fb;
            while (!taken && !timed_out) begin
                @(posedge clk);
                taken = in_ready;
                waited++;
                if (!taken && waited >= wait_limit) begin
                    timed_out = 1'b1;
                    $display("timeout: in_ready stayed low for %0d cycles", waited);
                end
            end
            if (taken) begin
                sent++;
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (chk_pending != 0 && !timed_out) begin
            @(negedge clk);
            waited++;
            if (chk_pending != 0 && waited >= wait_limit) begin
                timed_out = 1'b1;
                $display("timeout: %0d instructions never left the stage", chk_pending);
            end
        end
    endtask

    initial begin
        fetch_bundle_t fb;
        logic [31:0]   r1;
        int            total;
        clk          = 1'b0;
        arst_n       = 1'b1;
        in_valid     = 1'b0;
        in_bundle    = '0;
        out_ready    = 1'b0;
        wb           = '0;
        stim_state   = 32'h5c0f;
        stall_state  = ~32'h5c0f;
        timed_out    = 1'b0;
        sent         = 0;
        bench_errors = 0;
        #1 arst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(posedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            bench_errors++;
            $display("error: %0t ns: after reset out_valid=%b in_ready=%b",
                     $time, out_valid, in_ready);
        end
        preload_regs();
        for (int n = 0; n < num_insts; n++) begin
            r1      = next_stim();
            fb.pc   = {r1[31:2], 2'b00};
            r1      = next_stim();
            fb.inst = make_inst(r1, next_stim());
            send_inst(fb);
            // occasional idle cycle on the fetch side
            if (r1[31:29] == 3'd0) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
        end
        in_valid = 1'b0;
        wait_drain();
        total = bench_errors + chk_errors;
        if (chk_checked != sent) begin
            $display("%0d instructions went in but %0d came out", sent, chk_checked);
        end
        $display("sent %0d, checked %0d, errors %0d, timeouts %0d",
                 sent, chk_checked, total, timed_out);
        if (total == 0 && !timed_out && chk_checked == sent) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/id_checker.sv
`timescale 1ns/1ps
`default_nettype none

module id_checker (
    input  wire logic                        clk,
    input  wire logic                        arst_n,
    input  wire logic                        in_valid,
    input  wire logic                        in_ready,
    input  wire decode_pkg::fetch_bundle_t   in_bundle,
    input  wire logic                        out_valid,
    input  wire logic                        out_ready,
    input  wire decode_pkg::decoded_bundle_t out_bundle,
    input  wire decode_pkg::rf_write_t       wb,
    output int                               errors,
    output int                               checked,
    output int                               pending
);
    import decode_pkg::*;

    logic [31:0]     model_regs [32];
    decoded_bundle_t expect_q [$];
    logic [31:0]     inst_q [$];
    decoded_bundle_t want;
    logic [31:0]     want_inst;

    // expected bundle straight from the instruction set rules
    function automatic decoded_bundle_t predict_bundle(input logic [31:0] pc,
                                                       input logic [31:0] inst);
        decoded_bundle_t e;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [5:0]  fn;
        logic [31:0] a;
        logic [31:0] seq;
        logic        is_shift;
        logic        ok;
        logic        is_cond;
        logic        cond;
        logic        writes_rt;
        op        = inst[31:26];
        rs        = inst[25:21];
        rt        = inst[20:16];
        fn        = inst[5:0];
        a         = model_regs[rs];
        seq       = pc + 32'd4;
        is_cond   = 1'b0;
        cond      = 1'b0;
        e         = '0;
        e.pc          = pc;
        e.rs_value    = a;
        e.rt_value    = model_regs[rt];
        e.ctrl.dest   = inst[15:11];
        e.ctrl.imm    = inst[15:0];
        case (op)
            op_special: begin
                is_shift = (fn == funct_sll) || (fn == funct_srl) || (fn == funct_sra);
                ok = is_shift ? (rs == '0) : (inst[10:6] == '0);
                case (fn)
                    funct_addu: e.ctrl.alu_op = alu_add;
                    funct_subu: e.ctrl.alu_op = alu_sub;
                    funct_slt:  e.ctrl.alu_op = alu_slt;
                    funct_sltu: e.ctrl.alu_op = alu_sltu;
                    funct_and:  e.ctrl.alu_op = alu_and;
                    funct_or:   e.ctrl.alu_op = alu_or;
                    funct_xor:  e.ctrl.alu_op = alu_xor;
                    funct_nor:  e.ctrl.alu_op = alu_nor;
                    funct_sll:  e.ctrl.alu_op = alu_sll;
                    funct_srl:  e.ctrl.alu_op = alu_srl;
                    funct_sra:  e.ctrl.alu_op = alu_sra;
                    default:    ok = 1'b0;
                endcase
                if (!ok) begin
                    e.ctrl.alu_op = alu_add;
                end
                e.ctrl.gr_we      = ok;
                e.ctrl.src1_is_sa = ok && is_shift;
                // jr wants rt, rd and sa clear
                if (fn == funct_jr && inst[20:6] == '0) begin
                    e.branch.taken  = 1'b1;
                    e.branch.target = a;
                end
            end
            op_addiu: e.ctrl.alu_op = alu_add;
            op_slti:  e.ctrl.alu_op = alu_slt;
            op_sltiu: e.ctrl.alu_op = alu_sltu;
            op_andi:  e.ctrl.alu_op = alu_and;
            op_ori:   e.ctrl.alu_op = alu_or;
            op_xori:  e.ctrl.alu_op = alu_xor;
            op_lui: begin
                if (rs == '0) begin
                    e.ctrl.alu_op = alu_lui;
                end
            end
            op_lb, op_lbu, op_sb: e.ctrl.mem_size = mem_byte;
            op_lh, op_lhu, op_sh: e.ctrl.mem_size = mem_half;
            op_lw, op_sw:         e.ctrl.mem_size = mem_word;
            op_beq: begin
                is_cond = 1'b1;
                cond    = (a == e.rt_value);
            end
            op_bne: begin
                is_cond = 1'b1;
                cond    = (a != e.rt_value);
            end
            op_blez: begin
                is_cond = (rt == '0);
                cond    = ($signed(a) <= 0);
            end
            op_bgtz: begin
                is_cond = (rt == '0);
                cond    = ($signed(a) > 0);
            end
            op_regimm: begin
                is_cond = (rt == rt_bltz) || (rt == rt_bgez);
                cond    = (rt == rt_bgez) ? ($signed(a) >= 0) : ($signed(a) < 0);
            end
            op_j, op_jal: begin
                e.branch.taken  = 1'b1;
                e.branch.target = {seq[31:28], inst[25:0], 2'b00};
            end
            default: ;
        endcase
        writes_rt = (op inside {op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori})
                 || (op == op_lui && rs == '0);
        if (writes_rt) begin
            e.ctrl.src2_sel = (op inside {op_andi, op_ori, op_xori}) ? src2_zimm : src2_simm;
            e.ctrl.gr_we    = 1'b1;
            e.ctrl.dest     = rt;
        end
        // loads and stores add a signed offset to rs
        if (e.ctrl.mem_size != mem_none) begin
            e.ctrl.src2_sel    = src2_simm;
            e.ctrl.mem_store   = op inside {op_sb, op_sh, op_sw};
            e.ctrl.mem_load    = !e.ctrl.mem_store;
            e.ctrl.load_signed = (op == op_lb) || (op == op_lh);
            e.ctrl.gr_we       = e.ctrl.mem_load;
            if (e.ctrl.mem_load) begin
                e.ctrl.dest = rt;
            end
        end
        if (is_cond) begin
            e.branch.taken  = cond;
            e.branch.target = seq + {{14{inst[15]}}, inst[15:0], 2'b00};
        end
        if (op == op_jal) begin
            e.ctrl.gr_we = 1'b1;
            e.ctrl.dest  = 5'd31;
        end
        return e;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            expect_q.delete();
            inst_q.delete();
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("%0t ns: the stage sent a bundle with no instruction pending",
                             $time);
                end else begin
                    want      = expect_q.pop_front();
                    want_inst = inst_q.pop_front();
                    checked++;
                    if (out_bundle !== want) begin
                        errors++;
                        $display("error: %0t ns: inst %h at pc %h, expected %h, got %h",
                                 $time, want_inst, want.pc, want, out_bundle);
                    end
                end
            end
            if (in_valid && in_ready) begin
                expect_q.push_back(predict_bundle(in_bundle.pc, in_bundle.inst));
                inst_q.push_back(in_bundle.inst);
            end
            // register 0 stays zero in the model as well
            if (wb.we && wb.addr != '0) begin
                model_regs[wb.addr] = wb.data;
            end
        end
        pending = expect_q.size();
    end

endmodule

`default_nettype wire

// File: bench/id_properties.sv
`timescale 1ns/1ps
`default_nettype none

module id_properties (
    input wire logic                        clk,
    input wire logic                        arst_n,
    input wire logic                        in_ready,
    input wire logic                        fetch_valid,
    input wire logic                        out_valid,
    input wire logic                        out_ready,
    input wire decode_pkg::decoded_bundle_t out_bundle
);

    // a stalled output keeps both its valid and its payload
    property held_while_stalled;
        @(posedge clk) disable iff (!arst_n)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_bundle));
    endproperty

    a_held_while_stalled: assert property (held_while_stalled)
        else $error("out_bundle or out_valid changed while out_ready was low");

    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // room in either buffer means the fetch side can send
    a_ready_when_room: assert property (
        @(posedge clk) disable iff (!arst_n)
            !(fetch_valid && out_valid) |-> in_ready)
        else $error("in_ready low while the stage had room");

endmodule

bind id_stage id_properties u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_ready    (in_ready),
    .fetch_valid (fetch_valid),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_bundle  (out_bundle)
);

`default_nettype wire

// File: design/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic                       in_valid,
    output logic                            in_ready,
    input  wire decode_pkg::fetch_bundle_t  in_bundle,
    output logic                            out_valid,
    input  wire logic                       out_ready,
    output decode_pkg::decoded_bundle_t     out_bundle,
    input  wire decode_pkg::rf_write_t      wb
);
    import decode_pkg::*;

    fetch_bundle_t         fetch_q;
    logic                  fetch_valid;
    logic                  fetch_ready;
    logic [reg_addr_w-1:0] rs_addr;
    logic [reg_addr_w-1:0] rt_addr;
    logic [xlen-1:0]       rs_value;
    logic [xlen-1:0]       rt_value;
    ctrl_t                 ctrl;
    branch_t               branch;
    decoded_bundle_t       issue_d;

    // input buffer for fetched instructions
    pipe_reg #(
        .payload_t (fetch_bundle_t)
    ) u_fetch_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_bundle),
        .out_valid (fetch_valid),
        .out_ready (fetch_ready),
        .out_data  (fetch_q)
    );

    assign rs_addr = fetch_q.inst[25:21];
    assign rt_addr = fetch_q.inst[20:16];

    // operands read while the item sits in the input buffer
    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (rs_addr),
        .raddr2 (rt_addr),
        .rdata1 (rs_value),
        .rdata2 (rt_value),
        .wb     (wb)
    );

    inst_decoder u_inst_decoder (
        .inst (fetch_q.inst),
        .ctrl (ctrl)
    );

    branch_unit u_branch_unit (
        .pc       (fetch_q.pc),
        .inst     (fetch_q.inst),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .branch   (branch)
    );

    // merge decoder and branch results
    assign issue_d = '{
        pc:       fetch_q.pc,
        ctrl:     ctrl,
        rs_value: rs_value,
        rt_value: rt_value,
        branch:   branch
    };

    pipe_reg #(
        .payload_t (decoded_bundle_t)
    ) u_issue_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (issue_d),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_bundle)
    );

endmodule

`default_nettype wire

// File: design/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire logic [decode_pkg::xlen-1:0] pc,
    input  wire logic [decode_pkg::xlen-1:0] inst,
    input  wire logic [decode_pkg::xlen-1:0] rs_value,
    input  wire logic [decode_pkg::xlen-1:0] rt_value,
    output decode_pkg::branch_t              branch
);
    import decode_pkg::*;

    logic [5:0]            op;
    logic [reg_addr_w-1:0] rt;
    logic [5:0]            funct;
    logic [15:0]           offset;
    logic [25:0]           index;
    logic [xlen-1:0]       pc_plus4;
    logic inst_beq, inst_bne, inst_bgez, inst_bltz, inst_bgtz, inst_blez;
    logic inst_j, inst_jal, inst_jr;
    logic is_cond;
    logic rs_eq_rt;
    logic rs_eq_0;
    logic rs_lt_0;
    logic rs_gt_0;
    logic cond_taken;

    assign op     = inst[31:26];
    assign rt     = inst[20:16];
    assign funct  = inst[5:0];
    assign offset = inst[15:0];
    assign index  = inst[25:0];

    assign inst_beq  = (op == op_beq);
    assign inst_bne  = (op == op_bne);
    assign inst_bgez = (op == op_regimm) && (rt == rt_bgez);
    assign inst_bltz = (op == op_regimm) && (rt == rt_bltz);
    assign inst_bgtz = (op == op_bgtz) && (rt == '0);
    assign inst_blez = (op == op_blez) && (rt == '0);
    assign inst_j    = (op == op_j);
    assign inst_jal  = (op == op_jal);
    // jr needs rt, rd and sa all zero
    assign inst_jr   = (op == op_special) && (funct == funct_jr) && (inst[20:6] == '0);

    assign is_cond = inst_beq | inst_bne | inst_bgez | inst_bltz | inst_bgtz | inst_blez;

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_eq_0  = (rs_value == '0);
    assign rs_lt_0  = rs_value[xlen-1];
    assign rs_gt_0  = !rs_lt_0 && !rs_eq_0;

    assign cond_taken = (inst_beq  &&  rs_eq_rt)
                     || (inst_bne  && !rs_eq_rt)
                     || (inst_bgez && !rs_lt_0)
                     || (inst_bgtz &&  rs_gt_0)
                     || (inst_blez && (rs_lt_0 || rs_eq_0))
                     || (inst_bltz &&  rs_lt_0);

    // targets are relative to the branch's own pc plus 4
    assign pc_plus4 = pc + xlen'(4);

    always_comb begin
        branch.taken = cond_taken | inst_j | inst_jal | inst_jr;
        if (is_cond)
            branch.target = pc_plus4 + {{(xlen-18){offset[15]}}, offset, 2'b00};
        else if (inst_jr)
            branch.target = rs_value;
        else if (inst_j | inst_jal)
            branch.target = {pc_plus4[xlen-1:xlen-4], index, 2'b00};
        else
            branch.target = '0;
    end

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire logic [decode_pkg::xlen-1:0] inst,
    output decode_pkg::ctrl_t                ctrl
);
    import decode_pkg::*;

    logic [5:0]            op;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] sa;
    logic [5:0]            funct;
    logic                  r_alu;
    logic                  r_shift;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_lh, inst_lhu, inst_lb, inst_lbu, inst_sw, inst_sh, inst_sb;
    logic inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic inst_j, inst_jal;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic known;
    logic dst_is_rt;
    alu_op_t alu_op;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign sa    = inst[10:6];
    assign funct = inst[5:0];

    // register forms need sa zero, shifts need rs zero
    assign r_alu   = (op == op_special) && (sa == '0);
    assign r_shift = (op == op_special) && (rs == '0);

    assign inst_addu  = r_alu && (funct == funct_addu);
    assign inst_subu  = r_alu && (funct == funct_subu);
    assign inst_slt   = r_alu && (funct == funct_slt);
    assign inst_sltu  = r_alu && (funct == funct_sltu);
    assign inst_and   = r_alu && (funct == funct_and);
    assign inst_or    = r_alu && (funct == funct_or);
    assign inst_xor   = r_alu && (funct == funct_xor);
    assign inst_nor   = r_alu && (funct == funct_nor);
    assign inst_sll   = r_shift && (funct == funct_sll);
    assign inst_srl   = r_shift && (funct == funct_srl);
    assign inst_sra   = r_shift && (funct == funct_sra);
    assign inst_jr    = r_alu && (funct == funct_jr) && (rt == '0) && (rd == '0);
    assign inst_addiu = (op == op_addiu);
    assign inst_slti  = (op == op_slti);
    assign inst_sltiu = (op == op_sltiu);
    assign inst_andi  = (op == op_andi);
    assign inst_ori   = (op == op_ori);
    assign inst_xori  = (op == op_xori);
    assign inst_lui   = (op == op_lui) && (rs == '0);
    assign inst_lw    = (op == op_lw);
    assign inst_lh    = (op == op_lh);
    assign inst_lhu   = (op == op_lhu);
    assign inst_lb    = (op == op_lb);
    assign inst_lbu   = (op == op_lbu);
    assign inst_sw    = (op == op_sw);
    assign inst_sh    = (op == op_sh);
    assign inst_sb    = (op == op_sb);
    assign inst_beq   = (op == op_beq);
    assign inst_bne   = (op == op_bne);
    assign inst_bgez  = (op == op_regimm) && (rt == rt_bgez);
    assign inst_bltz  = (op == op_regimm) && (rt == rt_bltz);
    assign inst_bgtz  = (op == op_bgtz) && (rt == '0);
    assign inst_blez  = (op == op_blez) && (rt == '0);
    assign inst_j     = (op == op_j);
    assign inst_jal   = (op == op_jal);

    assign is_load   = inst_lw | inst_lh | inst_lhu | inst_lb | inst_lbu;
    assign is_store  = inst_sw | inst_sh | inst_sb;
    assign is_branch = inst_beq | inst_bne | inst_bgez | inst_bltz | inst_bgtz | inst_blez;
    assign known     = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                     | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra | inst_jr
                     | inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori | inst_lui | is_load | is_store | is_branch
                     | inst_j | inst_jal;
    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori | inst_lui | is_load;

    // address arithmetic and anything unlisted fall back to add
    always_comb begin
        if (inst_subu)                    alu_op = alu_sub;
        else if (inst_slt | inst_slti)    alu_op = alu_slt;
        else if (inst_sltu | inst_sltiu)  alu_op = alu_sltu;
        else if (inst_and | inst_andi)    alu_op = alu_and;
        else if (inst_nor)                alu_op = alu_nor;
        else if (inst_or | inst_ori)      alu_op = alu_or;
        else if (inst_xor | inst_xori)    alu_op = alu_xor;
        else if (inst_sll)                alu_op = alu_sll;
        else if (inst_srl)                alu_op = alu_srl;
        else if (inst_sra)                alu_op = alu_sra;
        else if (inst_lui)                alu_op = alu_lui;
        else                              alu_op = alu_add;
    end

    always_comb begin
        ctrl.alu_op     = alu_op;
        ctrl.src1_is_sa = inst_sll | inst_srl | inst_sra;
        if (inst_andi | inst_ori | inst_xori)
            ctrl.src2_sel = src2_zimm;
        else if (inst_addiu | inst_slti | inst_sltiu | inst_lui | is_load | is_store)
            ctrl.src2_sel = src2_simm;
        else
            ctrl.src2_sel = src2_reg;
        if (inst_lw | inst_sw)
            ctrl.mem_size = mem_word;
        else if (inst_lh | inst_lhu | inst_sh)
            ctrl.mem_size = mem_half;
        else if (inst_lb | inst_lbu | inst_sb)
            ctrl.mem_size = mem_byte;
        else
            ctrl.mem_size = mem_none;
        ctrl.mem_load    = is_load;
        ctrl.mem_store   = is_store;
        ctrl.load_signed = inst_lh | inst_lb;
        // unknown words pass through as no-ops
        ctrl.gr_we = known & ~is_store & ~is_branch & ~inst_j & ~inst_jr;
        ctrl.dest  = inst_jal  ? reg_addr_w'(31) :
                     dst_is_rt ? rt : rd;
        ctrl.imm   = inst[15:0];
    end

endmodule

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic [decode_pkg::reg_addr_w-1:0] raddr1,
    input  wire logic [decode_pkg::reg_addr_w-1:0] raddr2,
    output logic      [decode_pkg::xlen-1:0]       rdata1,
    output logic      [decode_pkg::xlen-1:0]       rdata2,
    input  wire decode_pkg::rf_write_t             wb
);
    import decode_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    // register 0 is never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // asynchronous reads see the old value on a same-cycle write
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: design/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    input  wire logic     out_ready,
    output payload_t      out_data
);

    logic     full;
    payload_t data_q;

    // a full entry can be replaced in the cycle it leaves
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule

`default_nettype wire

// File: design/decode_pkg.sv
`default_nettype none

package decode_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lh      = 6'h21;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_lbu     = 6'h24;
    localparam logic [5:0] op_lhu     = 6'h25;
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sh      = 6'h29;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special funct field
    localparam logic [5:0] funct_sll  = 6'h00;
    localparam logic [5:0] funct_srl  = 6'h02;
    localparam logic [5:0] funct_sra  = 6'h03;
    localparam logic [5:0] funct_jr   = 6'h08;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_xor  = 6'h26;
    localparam logic [5:0] funct_nor  = 6'h27;
    localparam logic [5:0] funct_slt  = 6'h2a;
    localparam logic [5:0] funct_sltu = 6'h2b;

    // regimm selector in the rt field
    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {
        src2_reg, src2_simm, src2_zimm
    } src2_sel_t;

    typedef enum logic [1:0] {
        mem_none, mem_byte, mem_half, mem_word
    } mem_size_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_bundle_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } rf_write_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  src1_is_sa;
        src2_sel_t             src2_sel;
        mem_size_t             mem_size;
        logic                  mem_load;
        logic                  mem_store;
        logic                  load_signed;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [15:0]           imm;
    } ctrl_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } branch_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        ctrl_t           ctrl;
        logic [xlen-1:0] rs_value;
        logic [xlen-1:0] rt_value;
        branch_t         branch;
    } decoded_bundle_t;

endpackage

`default_nettype wire
